//--- Makefile
TOP := tb_rsa

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- hdl/rsa_core.sv
`timescale 1ns/1ps

module rsa_core import rsa_pkg::*; (
    input logic      avm_clk,
    input logic      avm_rst,
    rsa_op_if.slave  op,
    rsa_op_if.master mont
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PREP,
        S_MUL,
        S_MUL_WAIT,
        S_SQR,
        S_SQR_WAIT
    } state_t;

    state_t                      state;
    logic [$clog2(rsa_bits)-1:0] cnt;
    logic                        done_r;
    logic [rsa_bits-1:0]         base;
    logic [rsa_bits-1:0]         result;
    logic [rsa_bits-1:0]         exp_sh;
    logic [rsa_bits:0]           dbl;
    logic [rsa_bits:0]           dbl_sub;
    logic                        cnt_last;

    assign dbl      = {base, 1'b0};
    assign dbl_sub  = dbl - {1'b0, op.n};
    assign cnt_last = (cnt == rsa_bits - 1);

    // Base is kept in Montgomery form, so the running result stays plain
    assign mont.start = ((state == S_MUL) && exp_sh[0]) || (state == S_SQR);
    assign mont.a     = ((state == S_SQR) || (state == S_SQR_WAIT)) ? base : result;
    assign mont.b     = base;
    assign mont.n     = op.n;

    assign op.result = result;
    assign op.done   = done_r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state  <= S_IDLE;
            cnt    <= '0;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (op.start) begin
                        cnt   <= '0;
                        state <= S_PREP;
                    end
                end
                S_PREP: begin
                    cnt <= cnt + 1'b1;   // Wraps to zero for the exponent loop
                    if (cnt_last) begin
                        state <= S_MUL;
                    end
                end
                S_MUL: begin
                    state <= exp_sh[0] ? S_MUL_WAIT : S_SQR;
                end
                S_MUL_WAIT: begin
                    if (mont.done) begin
                        state <= S_SQR;
                    end
                end
                S_SQR: begin
                    state <= S_SQR_WAIT;
                end
                S_SQR_WAIT: begin
                    if (mont.done) begin
                        cnt <= cnt + 1'b1;
                        if (cnt_last) begin
                            done_r <= 1'b1;
                            state  <= S_IDLE;
                        end else begin
                            state <= S_MUL;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        case (state)
            S_IDLE: begin
                if (op.start) begin
                    base   <= op.a;
                    result <= {{(rsa_bits-1){1'b0}}, 1'b1};
                    exp_sh <= op.b;
                end
            end
            S_PREP: begin
                // One doubling per cycle, reduced mod n
                base <= (dbl >= {1'b0, op.n}) ? dbl_sub[rsa_bits-1:0] : dbl[rsa_bits-1:0];
            end
            S_MUL_WAIT: begin
                if (mont.done) begin
                    result <= mont.result;
                end
            end
            S_SQR_WAIT: begin
                if (mont.done) begin
                    base   <= mont.result;
                    exp_sh <= exp_sh >> 1;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/rsa_mont.sv
`timescale 1ns/1ps

module rsa_mont import rsa_pkg::*; (
    input logic     avm_clk,
    input logic     avm_rst,
    rsa_op_if.slave op
);

    logic [rsa_bits+1:0]       acc;
    logic [rsa_bits+1:0]       acc_add_b;
    logic [rsa_bits+1:0]       acc_add_n;
    logic [rsa_bits-1:0]       a_sh;
    logic [$clog2(rsa_bits):0] cnt;
    logic                      busy;
    logic                      done_r;
    logic                      last_step;

    assign last_step = busy && (cnt == rsa_bits);

    // Accumulator stays below 2n, so two guard bits cover the sum
    always_comb begin
        acc_add_b = a_sh[0] ? acc + {2'b00, op.b} : acc;
        acc_add_n = acc_add_b[0] ? acc_add_b + {2'b00, op.n} : acc_add_b;
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (op.start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (last_step) begin
                busy   <= 1'b0;
                done_r <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (op.start) begin
            acc  <= '0;
            a_sh <= op.a;
        end else if (last_step) begin
            if (acc >= {2'b00, op.n}) begin
                acc <= acc - {2'b00, op.n};   // Bring the product below n
            end
        end else if (busy) begin
            acc  <= acc_add_n >> 1;   // Low bit is zero after adding n
            a_sh <= a_sh >> 1;
        end
    end

    assign op.result = acc[rsa_bits-1:0];
    assign op.done   = done_r;

endmodule

//--- hdl/rsa_op_if.sv
`timescale 1ns/1ps

interface rsa_op_if import rsa_pkg::*; ();

    logic                start;    // One-cycle request pulse
    logic [rsa_bits-1:0] a;
    logic [rsa_bits-1:0] b;
    logic [rsa_bits-1:0] n;        // Modulus, odd
    logic [rsa_bits-1:0] result;   // Valid in the done cycle
    logic                done;

    modport master (
        output start,
        output a,
        output b,
        output n,
        input  result,
        input  done
    );

    modport slave (
        input  start,
        input  a,
        input  b,
        input  n,
        output result,
        output done
    );

endinterface

//--- hdl/rsa_pkg.sv
package rsa_pkg;

    localparam int rsa_bits = 256;
    localparam int addr_w   = 5;

    // Word offsets of the serial peripheral registers
    localparam logic [addr_w-1:0] rx_base     = 5'd0;
    localparam logic [addr_w-1:0] tx_base     = 5'd4;
    localparam logic [addr_w-1:0] status_base = 5'd8;

    localparam int rx_ok_bit = 7;   // Status bit for a byte waiting in RX
    localparam int tx_ok_bit = 6;   // Status bit for room in TX

    localparam int key_bytes   = 32;
    localparam int block_bytes = 96;   // Modulus, exponent and ciphertext
    localparam int send_bytes  = 31;   // Top byte of the result is never sent

endpackage

//--- hdl/rsa_top.sv
`timescale 1ns/1ps

module rsa_top import rsa_pkg::*; (
    input  logic              avm_clk,
    input  logic              avm_rst,
    output logic [addr_w-1:0] avm_address,
    output logic              avm_read,
    input  logic [31:0]       avm_readdata,
    output logic              avm_write,
    output logic [31:0]       avm_writedata,
    input  logic              avm_waitrequest
);

    rsa_op_if core_link ();   // Exponentiation request from the bus side
    rsa_op_if mont_link ();   // Single Montgomery product

    rsa_wrapper u_wrapper (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .core            (core_link.master)
    );

    rsa_core u_core (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .op      (core_link.slave),
        .mont    (mont_link.master)
    );

    rsa_mont u_mont (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .op      (mont_link.slave)
    );

endmodule

//--- hdl/rsa_wrapper.sv
`timescale 1ns/1ps

module rsa_wrapper import rsa_pkg::*; (
    input  logic              avm_clk,
    input  logic              avm_rst,
    output logic [addr_w-1:0] avm_address,
    output logic              avm_read,
    input  logic [31:0]       avm_readdata,
    output logic              avm_write,
    output logic [31:0]       avm_writedata,
    input  logic              avm_waitrequest,
    rsa_op_if.master          core
);

    typedef enum logic [2:0] {
        S_READ_READY,
        S_GET_PU_KEY,
        S_GET_PR_KEY,
        S_GET_DATA,
        S_WAIT_CALCULATE,
        S_WRITE_READY,
        S_SEND_DATA
    } state_t;

    state_t                         state;
    logic [$clog2(block_bytes)-1:0] cnt;
    logic [$clog2(key_bytes)-1:0]   byte_sel;
    logic [addr_w-1:0]              addr_r;
    logic                           read_r;
    logic                           write_r;
    logic                           start_r;
    logic [rsa_bits-1:0]            n_r;
    logic [rsa_bits-1:0]            d_r;
    logic [rsa_bits-1:0]            enc_r;
    logic [rsa_bits-1:0]            dec_r;

    assign byte_sel = cnt[$clog2(key_bytes)-1:0];   // Byte position inside the current value

    assign avm_address   = addr_r;
    assign avm_read      = read_r;
    assign avm_write     = write_r;
    assign avm_writedata = {24'd0, dec_r[rsa_bits-9 -: 8]};   // Byte 30 moves up after each shift

    assign core.start = start_r;
    assign core.a     = enc_r;
    assign core.b     = d_r;
    assign core.n     = n_r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state   <= S_READ_READY;
            cnt     <= '0;
            addr_r  <= status_base;
            read_r  <= 1'b1;
            write_r <= 1'b0;
            start_r <= 1'b0;
        end else begin
            start_r <= 1'b0;
            case (state)
                S_READ_READY: begin
                    if (!avm_waitrequest && avm_readdata[rx_ok_bit]) begin
                        addr_r <= rx_base;
                        if (cnt < key_bytes) begin
                            state <= S_GET_PU_KEY;
                        end else if (cnt < 2 * key_bytes) begin
                            state <= S_GET_PR_KEY;
                        end else begin
                            state <= S_GET_DATA;
                        end
                    end
                end
                S_GET_PU_KEY, S_GET_PR_KEY, S_GET_DATA: begin
                    if (!avm_waitrequest) begin
                        addr_r <= status_base;
                        if (cnt == block_bytes - 1) begin
                            cnt     <= '0;
                            start_r <= 1'b1;
                            state   <= S_WAIT_CALCULATE;
                        end else begin
                            cnt   <= cnt + 1'b1;
                            state <= S_READ_READY;
                        end
                    end
                end
                S_WAIT_CALCULATE: begin
                    if (core.done) begin
                        state <= S_WRITE_READY;   // Status read stays posted meanwhile
                    end
                end
                S_WRITE_READY: begin
                    if (!avm_waitrequest && avm_readdata[tx_ok_bit]) begin
                        read_r  <= 1'b0;
                        write_r <= 1'b1;
                        addr_r  <= tx_base;
                        state   <= S_SEND_DATA;
                    end
                end
                S_SEND_DATA: begin
                    if (!avm_waitrequest) begin
                        read_r  <= 1'b1;
                        write_r <= 1'b0;
                        addr_r  <= status_base;
                        if (cnt == send_bytes - 1) begin
                            cnt   <= '0;
                            state <= S_READ_READY;
                        end else begin
                            cnt   <= cnt + 1'b1;
                            state <= S_WRITE_READY;
                        end
                    end
                end
                default: state <= S_READ_READY;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (!avm_waitrequest) begin
            case (state)
                S_GET_PU_KEY: n_r[{byte_sel, 3'b000} +: 8]   <= avm_readdata[7:0];
                S_GET_PR_KEY: d_r[{byte_sel, 3'b000} +: 8]   <= avm_readdata[7:0];
                S_GET_DATA:   enc_r[{byte_sel, 3'b000} +: 8] <= avm_readdata[7:0];
                S_SEND_DATA:  dec_r <= dec_r << 8;
                default: ;
            endcase
        end
        if ((state == S_WAIT_CALCULATE) && core.done) begin
            dec_r <= core.result;
        end
    end

endmodule

//--- sources.f
hdl/rsa_pkg.sv
hdl/rsa_op_if.sv
hdl/rsa_mont.sv
hdl/rsa_core.sv
hdl/rsa_wrapper.sv
hdl/rsa_top.sv
verif/tb_uart_slave.sv
verif/tb_rsa.sv

//--- verif/tb_rsa.sv
`timescale 1ns/1ps

module tb_rsa import rsa_pkg::*; ();

    localparam int num_blocks = 3;
    localparam int rx_total   = num_blocks * block_bytes;
    localparam int tx_total   = num_blocks * send_bytes;
    // Up to about 133000 core cycles per block plus status polling under stalls
    localparam int max_cycles = num_blocks * 200000;

    logic              avm_clk = 1'b0;
    logic              avm_rst;
    logic [addr_w-1:0] avm_address;
    logic              avm_read;
    logic [31:0]       avm_readdata;
    logic              avm_write;
    logic [31:0]       avm_writedata;
    logic              avm_waitrequest;

    logic [7:0] rx_data [rx_total];
    logic [7:0] expect_bytes [tx_total];
    logic       tx_valid;
    logic [7:0] tx_byte;
    int         rx_count;
    int         tx_count;
    logic       violation;
    int         seed;
    int         cycles = 0;
    int         tx_seen = 0;

    rsa_top dut0 (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    tb_uart_slave #(.rx_depth(rx_total)) slave0 (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .rx_data         (rx_data),
        .tx_valid        (tx_valid),
        .tx_byte         (tx_byte),
        .rx_count        (rx_count),
        .tx_count        (tx_count),
        .violation       (violation)
    );

    initial begin
        forever #10 avm_clk = ~avm_clk;
    end

    task automatic check_value(input string name, input logic [rsa_bits-1:0] got,
                               input logic [rsa_bits-1:0] want);
        if (got !== want) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, want);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [rsa_bits-1:0] rand_wide();
        logic [rsa_bits-1:0] v;
        for (int i = 0; i < rsa_bits / 32; i++) begin
            v[32*i +: 32] = $random(seed);
        end
        return v;
    endfunction

    // Plain square-and-multiply, products kept in double width before the reduction
    function automatic logic [rsa_bits-1:0] mod_pow(input logic [rsa_bits-1:0] base,
                                                    input logic [rsa_bits-1:0] exp,
                                                    input logic [rsa_bits-1:0] n);
        logic [2*rsa_bits-1:0] r;
        logic [2*rsa_bits-1:0] b;
        logic [2*rsa_bits-1:0] m;
        r = 1;
        b = {{rsa_bits{1'b0}}, base};
        m = {{rsa_bits{1'b0}}, n};
        for (int i = 0; i < rsa_bits; i++) begin
            if (exp[i]) begin
                r = (r * b) % m;
            end
            b = (b * b) % m;
        end
        return r[rsa_bits-1:0];
    endfunction

    task automatic make_blocks();
        logic [rsa_bits-1:0] n;
        logic [rsa_bits-1:0] d;
        logic [rsa_bits-1:0] c;
        logic [rsa_bits-1:0] m;
        for (int k = 0; k < num_blocks; k++) begin
            n = rand_wide();
            n[rsa_bits-1] = 1'b1;
            n[0] = 1'b1;
            d = rand_wide();
            c = rand_wide() % n;
            m = mod_pow(c, d, n);
            for (int i = 0; i < key_bytes; i++) begin
                rx_data[k*block_bytes + i]               = n[8*i +: 8];
                rx_data[k*block_bytes + key_bytes + i]   = d[8*i +: 8];
                rx_data[k*block_bytes + 2*key_bytes + i] = c[8*i +: 8];
            end
            for (int i = 0; i < send_bytes; i++) begin
                expect_bytes[k*send_bytes + i] = m[8*(send_bytes-1-i) +: 8];   // Byte 30 first
            end
        end
    endtask

    always @(posedge avm_clk) begin
        if (!avm_rst && tx_valid) begin
            check_value("avm_writedata", tx_byte, expect_bytes[tx_seen]);
            // Every byte of a block goes out after all of its input and before the next
            check_value("rx_count", rx_count, (tx_seen / send_bytes + 1) * block_bytes);
            tx_seen = tx_seen + 1;
        end
    end

    always @(posedge avm_clk) begin
        if (violation) begin
            $display(">>> FAIL");
            $fatal(1, "bus protocol broken");
        end
    end

    always @(posedge avm_clk) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: only %0d of %0d result bytes after %0d cycles",
                     tx_seen, tx_total, max_cycles);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed    = 24649;
        avm_rst = 1'b1;
        make_blocks();
        repeat (2) @(negedge avm_clk);
        check_value("avm_read", avm_read, 1'b1);
        check_value("avm_write", avm_write, 1'b0);
        check_value("avm_address", avm_address, status_base);
        @(negedge avm_clk);
        avm_rst <= 1'b0;
        wait (tx_seen == tx_total);
        repeat (20) @(negedge avm_clk);   // Room for a stray transfer to show up
        check_value("tx_count", tx_count, tx_total);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verif/tb_uart_slave.sv
`timescale 1ns/1ps

module tb_uart_slave import rsa_pkg::*; #(
    parameter int rx_depth = block_bytes
) (
    input  logic              avm_clk,
    input  logic              avm_rst,
    input  logic [addr_w-1:0] avm_address,
    input  logic              avm_read,
    output logic [31:0]       avm_readdata,
    input  logic              avm_write,
    input  logic [31:0]       avm_writedata,
    output logic              avm_waitrequest,
    input  logic [7:0]        rx_data [rx_depth],
    output logic              tx_valid,
    output logic [7:0]        tx_byte,
    output int                rx_count,
    output int                tx_count,
    output logic              violation
);

    int          seed;
    logic [31:0] r;
    logic        rx_ok;
    logic        tx_ok;
    logic        rx_ok_seen;   // Bit 7 as returned by the latest accepted status read
    logic        tx_ok_seen;   // Bit 6 likewise

    initial begin
        seed            = 24649;
        avm_waitrequest = 1'b1;
        avm_readdata    = '0;
        tx_valid        = 1'b0;
        tx_byte         = '0;
        rx_count        = 0;
        tx_count        = 0;
        violation       = 1'b0;
        rx_ok_seen      = 1'b0;
        tx_ok_seen      = 1'b0;
    end

    task automatic flag_violation(input string what);
        $display("bus slave at %0t: %s", $time, what);
        violation <= 1'b1;
    endtask

    // Outputs change on the falling edge, so acceptance is known before the DUT samples
    always @(negedge avm_clk) begin
        r        = $random(seed);
        rx_ok    = (rx_count < rx_depth) && r[2];
        tx_ok    = r[3];
        tx_valid <= 1'b0;
        if (avm_rst) begin
            avm_waitrequest <= 1'b1;
        end else begin
            if (avm_read && avm_write) begin
                flag_violation("read and write are both high in one cycle");
            end
            avm_waitrequest <= r[0];
            if (r[0] || !(avm_read || avm_write)) begin
                avm_readdata <= $random(seed);   // Junk the DUT must ignore
            end else if (avm_read && avm_address == status_base) begin
                avm_readdata <= {24'd0, rx_ok, tx_ok, 6'd0};
                rx_ok_seen   <= rx_ok;
                tx_ok_seen   <= tx_ok;
            end else if (avm_read && avm_address == rx_base) begin
                if (!rx_ok_seen || rx_count >= rx_depth) begin
                    flag_violation("RX was read while status showed no byte waiting");
                end else begin
                    avm_readdata <= {24'd0, rx_data[rx_count]};
                    rx_count     <= rx_count + 1;
                    rx_ok_seen   <= 1'b0;
                end
            end else if (avm_write && avm_address == tx_base) begin
                if (!tx_ok_seen) begin
                    flag_violation("TX was written without status showing room");
                end else if (avm_writedata[31:8] != 24'd0) begin
                    flag_violation("TX write carries nonzero upper bits");
                end else begin
                    tx_valid   <= 1'b1;
                    tx_byte    <= avm_writedata[7:0];
                    tx_count   <= tx_count + 1;
                    tx_ok_seen <= 1'b0;
                end
            end else begin
                flag_violation("transfer to an address the peripheral does not decode");
            end
        end
    end

endmodule
